//--- hdl/llc_pkg.sv
// --------------------------------------------------
// llc local store geometry and shared types
// --------------------------------------------------
`default_nettype none

package llc_pkg;

    localparam int LLC_WAYS       = 4;
    localparam int LLC_WAY_BITS   = 2;
    localparam int LLC_SET_BITS   = 6;
    localparam int LLC_TAG_BITS   = 12;
    localparam int LLC_STATE_BITS = 3;
    localparam int LLC_LINE_BITS  = 32;

    // top set bits that pick a bank, per field
    localparam int TAG_BANK_BITS   = 1;
    localparam int STATE_BANK_BITS = 1;
    localparam int DIRTY_BANK_BITS = 1;
    localparam int EVICT_BANK_BITS = 1;
    localparam int LINE_BANK_BITS  = 2;

    typedef logic [LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [LLC_WAY_BITS-1:0]   llc_way_t;
    typedef logic [LLC_WAYS-1:0]       llc_way_mask_t;
    typedef logic [LLC_TAG_BITS-1:0]   llc_tag_t;
    typedef logic [LLC_STATE_BITS-1:0] llc_state_t;
    typedef logic [LLC_LINE_BITS-1:0]  line_t;

    // one write request, shared by all ways
    typedef struct packed {
        llc_set_t   set;
        llc_way_t   way;
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        line_t      line;
    } llc_wr_req_t;

    // what one way returns on a read
    typedef struct packed {
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        line_t      line;
    } llc_entry_t;

    typedef llc_entry_t [LLC_WAYS-1:0] llc_rd_data_t;

endpackage

`default_nettype wire

//--- hdl/llc_bank_ram.sv
// --------------------------------------------------
// llc bank RAM
// simple dual-port array, registered enabled read
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module llc_bank_ram #(
    parameter type payload_t = logic,
    parameter int  ROW_BITS  = 5
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                wr_en,
    input  wire logic [ROW_BITS-1:0] wr_row,
    input  wire payload_t            wr_data,
    input  wire logic                rd_en,
    input  wire logic [ROW_BITS-1:0] rd_row,
    output payload_t                 rd_data
);

    payload_t mem [2**ROW_BITS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_data;
        end
    end

    // same-row read and write in one cycle sees the old word
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

endmodule

`default_nettype wire

//--- hdl/llc_field_array.sv
// --------------------------------------------------
// llc field array
// one field over banks, write decode and read mux
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module llc_field_array
    import llc_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  BANK_BITS = 1
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     wr_en,
    input  wire llc_set_t wr_set,
    input  wire payload_t wr_data,
    input  wire logic     rd_en,
    input  wire llc_set_t rd_set,
    output payload_t      rd_data
);

    localparam int NUM_BANKS = 2**BANK_BITS;
    localparam int ROW_BITS  = LLC_SET_BITS - BANK_BITS;

    logic [BANK_BITS-1:0] wr_bank;
    logic [BANK_BITS-1:0] rd_bank;
    logic [BANK_BITS-1:0] rd_bank_q;
    logic [NUM_BANKS-1:0] bank_wr;
    payload_t             bank_rd [NUM_BANKS];

    assign wr_bank = wr_set[LLC_SET_BITS-1 -: BANK_BITS];
    assign rd_bank = rd_set[LLC_SET_BITS-1 -: BANK_BITS];

    // bank index follows the bank output registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_bank_q <= '0;
        end else if (rd_en) begin
            rd_bank_q <= rd_bank;
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_wr[b] = wr_en && (wr_bank == BANK_BITS'(b));

        llc_bank_ram #(
            .payload_t (payload_t),
            .ROW_BITS  (ROW_BITS)
        ) u_ram (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (bank_wr[b]),
            .wr_row  (wr_set[ROW_BITS-1:0]),
            .wr_data (wr_data),
            .rd_en   (rd_en),
            .rd_row  (rd_set[ROW_BITS-1:0]),
            .rd_data (bank_rd[b])
        );
    end

    assign rd_data = bank_rd[rd_bank_q];

    // a write lands in exactly one bank
    a_one_bank_wr : assert property (
        @(posedge clk) disable iff (!rst)
        wr_en |-> $onehot(bank_wr)
    );

endmodule

`default_nettype wire

//--- hdl/llc_way_store.sv
// --------------------------------------------------
// llc way store
// tag, state, dirty and line arrays of one way
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module llc_way_store
    import llc_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        way_wr,
    input  wire logic        way_flush,
    input  wire llc_wr_req_t wr_req,
    input  wire logic        rd_en,
    input  wire llc_set_t    rd_set,
    output llc_entry_t       entry
);

    // flush only touches state and dirty
    logic meta_wr;

    assign meta_wr = way_wr || way_flush;

    llc_field_array #(.payload_t(llc_tag_t), .BANK_BITS(TAG_BANK_BITS)) u_tag (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (way_wr),
        .wr_set  (wr_req.set),
        .wr_data (wr_req.tag),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_data (entry.tag)
    );

    llc_field_array #(.payload_t(llc_state_t), .BANK_BITS(STATE_BANK_BITS)) u_state (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (meta_wr),
        .wr_set  (wr_req.set),
        .wr_data (wr_req.state),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_data (entry.state)
    );

    llc_field_array #(.payload_t(logic), .BANK_BITS(DIRTY_BANK_BITS)) u_dirty (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (meta_wr),
        .wr_set  (wr_req.set),
        .wr_data (wr_req.dirty),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_data (entry.dirty)
    );

    llc_field_array #(.payload_t(line_t), .BANK_BITS(LINE_BANK_BITS)) u_line (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (way_wr),
        .wr_set  (wr_req.set),
        .wr_data (wr_req.line),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_data (entry.line)
    );

endmodule

`default_nettype wire

//--- hdl/llc_localmem.sv
// --------------------------------------------------
// llc local memory
// set-associative tag and data store with evict way
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module llc_localmem
    import llc_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          rd_en,
    input  wire llc_set_t      rd_set,
    input  wire logic          wr_en,
    input  wire llc_wr_req_t   wr_req,
    input  wire llc_way_mask_t flush_mask,
    input  wire logic          wr_en_evict_way,
    input  wire llc_way_t      wr_evict_way,
    output llc_rd_data_t       rd_data,
    output llc_way_t           rd_evict_way
);

    llc_way_mask_t way_wr;
    logic          flush;

    assign flush = |flush_mask;

    for (genvar w = 0; w < LLC_WAYS; w++) begin : g_way
        // normal write goes to the addressed way only
        assign way_wr[w] = wr_en && (wr_req.way == llc_way_t'(w));

        llc_way_store u_way (
            .clk       (clk),
            .rst       (rst),
            .way_wr    (way_wr[w]),
            .way_flush (flush_mask[w]),
            .wr_req    (wr_req),
            .rd_en     (rd_en),
            .rd_set    (rd_set),
            .entry     (rd_data[w])
        );
    end

    // shared by all ways, written on its own
    llc_field_array #(.payload_t(llc_way_t), .BANK_BITS(EVICT_BANK_BITS)) u_evict_way (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en_evict_way),
        .wr_set  (wr_req.set),
        .wr_data (wr_evict_way),
        .rd_en   (rd_en),
        .rd_set  (rd_set),
        .rd_data (rd_evict_way)
    );

    // a flush and a normal write share the state and dirty write port
    a_wr_flush_excl : assert property (
        @(posedge clk) disable iff (!rst)
        !(wr_en && flush)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// --------------------------------------------------
// testbench clock and reset, 20 ns period
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low over the first two rising edges
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/llc_localmem_tb.sv
// --------------------------------------------------
// llc local memory testbench, vector file and random traffic
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module llc_localmem_tb
    import llc_pkg::*;
();

    localparam int MAX_VEC     = 128;
    localparam int RAND_WRITES = 40;
    localparam logic [3:0] OP_END        = 4'h0;
    localparam logic [3:0] OP_WRITE      = 4'h1;
    localparam logic [3:0] OP_FLUSH      = 4'h2;
    localparam logic [3:0] OP_EVICT      = 4'h3;
    localparam logic [3:0] OP_READ       = 4'h4;
    localparam logic [3:0] OP_READ_EVICT = 4'h5;
    localparam logic [3:0] OP_HOLD       = 4'h6;
    localparam logic [3:0] OP_STOP       = 4'hf;

    // one line of the vector file
    typedef struct packed {
        logic [3:0]    op;
        llc_set_t      set;
        llc_way_mask_t sel;    // way index, or flush mask
        llc_tag_t      tag;
        llc_state_t    state;
        logic          dirty;
        line_t         line;
        llc_way_t      evict;
    } vec_rec_t;

    logic          clk;
    logic          rst;
    logic          rd_en;
    llc_set_t      rd_set;
    logic          wr_en;
    llc_wr_req_t   wr_req;
    llc_way_mask_t flush_mask;
    logic          wr_en_evict_way;
    llc_way_t      wr_evict_way;
    llc_rd_data_t  rd_data;
    llc_way_t      rd_evict_way;

    logic [31:0]   vw [MAX_VEC*8];
    vec_rec_t      pend;
    llc_entry_t    ref_entry [64][LLC_WAYS];
    llc_way_mask_t touched [64];
    string         test_name [6];
    integer        seed;
    int            nvec;
    int            limit;
    int            cycles;
    int            test_idx;
    int            test_errs;
    int            pass_tests;
    int            fail_tests;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    llc_localmem dut (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic vec_rec_t get_rec(input int i);
        vec_rec_t rec;
        rec.op    = vw[8*i][3:0];
        rec.set   = vw[8*i+1][5:0];
        rec.sel   = vw[8*i+2][3:0];
        rec.tag   = vw[8*i+3][11:0];
        rec.state = vw[8*i+4][2:0];
        rec.dirty = vw[8*i+5][0];
        rec.line  = vw[8*i+6];
        rec.evict = vw[8*i+7][1:0];
        return rec;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic check_entry(input int way, input llc_entry_t exp);
        compare_field($sformatf("rd_data[%0d].tag", way), 32'(exp.tag),
                      32'(rd_data[way].tag));
        compare_field($sformatf("rd_data[%0d].state", way), 32'(exp.state),
                      32'(rd_data[way].state));
        compare_field($sformatf("rd_data[%0d].dirty", way), 32'(exp.dirty),
                      32'(rd_data[way].dirty));
        compare_field($sformatf("rd_data[%0d].line", way), exp.line, rd_data[way].line);
    endtask

    task automatic check_pending();
        llc_entry_t exp;
        exp = '{tag: pend.tag, state: pend.state, dirty: pend.dirty, line: pend.line};
        if (pend.op == OP_READ || pend.op == OP_HOLD) begin
            check_entry(int'(pend.sel[1:0]), exp);
        end else if (pend.op == OP_READ_EVICT) begin
            compare_field("rd_evict_way", 32'(pend.evict), 32'(rd_evict_way));
        end
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            pass_tests++;
            $display("test %0d %s: ok", test_idx + 1, test_name[test_idx]);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d mismatches", test_idx + 1, test_name[test_idx],
                     test_errs);
        end
        test_idx++;
        test_errs = 0;
    endtask

    task automatic set_idle();
        rd_en = 1'b0;
        wr_en = 1'b0;
        flush_mask = '0;
        wr_en_evict_way = 1'b0;
    endtask

    task automatic apply_vector(input vec_rec_t rec);
        @(negedge clk);
        check_pending();
        set_idle();
        pend = rec;
        wr_req = '{set: rec.set, way: rec.sel[1:0], tag: rec.tag, state: rec.state,
                   dirty: rec.dirty, line: rec.line};
        wr_evict_way = rec.evict;
        case (rec.op)
            OP_END:   report_test();
            OP_WRITE: wr_en = 1'b1;
            OP_FLUSH: flush_mask = rec.sel;
            OP_EVICT: wr_en_evict_way = 1'b1;
            OP_READ, OP_READ_EVICT: begin
                rd_en = 1'b1;
                rd_set = rec.set;
            end
            OP_HOLD:  rd_set = rec.set;
            default:  ;
        endcase
    endtask

    task automatic run_random();
        logic [31:0] r;
        logic [31:0] d;
        llc_set_t    s;
        llc_way_t    w;
        for (int k = 0; k < RAND_WRITES; k++) begin
            @(negedge clk);
            r = $random(seed);
            d = $random(seed);
            s = r[5:0];
            w = r[9:8];
            set_idle();
            wr_req = '{set: s, way: w, tag: r[27:16], state: r[14:12], dirty: r[31], line: d};
            wr_en = 1'b1;
            // last write to a set and way wins
            ref_entry[s][w] = '{tag: r[27:16], state: r[14:12], dirty: r[31], line: d};
            touched[s][w] = 1'b1;
        end
        @(negedge clk);
        set_idle();
        for (int i = 0; i < 64; i++) begin
            if (touched[i] != '0) begin
                rd_en = 1'b1;
                rd_set = llc_set_t'(i);
                @(negedge clk);
                rd_en = 1'b0;
                for (int j = 0; j < LLC_WAYS; j++) begin
                    if (touched[i][j]) check_entry(j, ref_entry[i][j]);
                end
            end
        end
        report_test();
    endtask

    initial begin
        set_idle();
        rd_set = '0;
        wr_req = '0;
        wr_evict_way = '0;
        pend = '0;
        seed = 61910;
        cycles = 0;
        test_idx = 0;
        test_errs = 0;
        pass_tests = 0;
        fail_tests = 0;
        test_name = '{"write and read back", "bank separation", "flush", "evict way",
                      "read hold", "random traffic"};
        foreach (touched[i]) touched[i] = '0;
        $readmemh("testbench/llc_localmem_vectors.txt", vw);
        nvec = 0;
        while (nvec < MAX_VEC && vw[8*nvec][3:0] != OP_STOP) nvec++;
        limit = 2 * nvec + 2 * RAND_WRITES + 50;

        @(posedge rst);
        for (int i = 0; i < nvec; i++) apply_vector(get_rec(i));
        run_random();

        $display("%0d tests ok, %0d tests failed", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/llc_localmem_vectors.txt
// op set sel tag state dirty line evict (sel is the way, or the flush mask)
// op: 0 end of test, 1 write, 2 flush, 3 evict write, 4 read, 5 read evict, 6 hold, f stop
1 05 0 abc 3 1 11112222 0
1 05 1 123 5 0 33334444 0
1 05 3 fed 7 1 deadbeef 0
4 05 0 abc 3 1 11112222 0
4 05 1 123 5 0 33334444 0
4 05 3 fed 7 1 deadbeef 0
0 00 0 000 0 0 00000000 0
1 00 2 100 1 0 a0000000 0
1 10 2 101 1 0 a1111111 0
1 20 2 102 1 0 a2222222 0
1 30 2 103 1 0 a3333333 0
4 00 2 100 1 0 a0000000 0
4 10 2 101 1 0 a1111111 0
4 20 2 102 1 0 a2222222 0
4 30 2 103 1 0 a3333333 0
0 00 0 000 0 0 00000000 0
1 2a 0 200 1 1 c0c0c0c0 0
1 2a 1 201 2 1 c1c1c1c1 0
1 2a 2 202 3 1 c2c2c2c2 0
1 2a 3 203 4 1 c3c3c3c3 0
2 2a 5 000 6 0 00000000 0
4 2a 0 200 6 0 c0c0c0c0 0
4 2a 1 201 2 1 c1c1c1c1 0
4 2a 2 202 6 0 c2c2c2c2 0
4 2a 3 203 4 1 c3c3c3c3 0
0 00 0 000 0 0 00000000 0
1 03 1 333 2 1 0badf00d 0
1 28 2 444 5 0 feedface 0
3 03 0 000 0 0 00000000 2
3 28 0 000 0 0 00000000 1
5 03 0 000 0 0 00000000 2
5 28 0 000 0 0 00000000 1
4 03 1 333 2 1 0badf00d 0
4 28 2 444 5 0 feedface 0
0 00 0 000 0 0 00000000 0
1 0c 0 555 1 1 12345678 0
4 0c 0 555 1 1 12345678 0
6 13 0 555 1 1 12345678 0
1 0c 0 666 2 0 87654321 0
6 0c 0 555 1 1 12345678 0
4 0c 0 666 2 0 87654321 0
0 00 0 000 0 0 00000000 0
f 00 0 000 0 0 00000000 0

//--- llc_localmem.f
hdl/llc_pkg.sv
hdl/llc_bank_ram.sv
hdl/llc_field_array.sv
hdl/llc_way_store.sv
hdl/llc_localmem.sv
testbench/tb_clock_gen.sv
testbench/llc_localmem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module llc_localmem_tb \
    -f llc_localmem.f \
    -o llc_localmem_sim

./obj_dir/llc_localmem_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
